//--- lc3b_types.sv
package lc3b_types;

    // Data, address and instruction word
    typedef logic [15:0] lc3b_word;

    // General register index, R0 to R7
    typedef logic [2:0] lc3b_reg;

    // Condition codes ordered n, z, p from the top bit down
    typedef logic [2:0] lc3b_nzp;

    // Only the opcodes this core executes
    // Anything else retires as a no-op
    typedef enum logic [3:0] {
        op_br  = 4'b0000,
        op_add = 4'b0001,
        op_and = 4'b0101,
        op_ldr = 4'b0110,
        op_str = 4'b0111,
        op_not = 4'b1001
    } lc3b_opcode;

    // Operate and memory layout
    //   ADD/AND reg : opcode dr sr1 0 00 sr2
    //   ADD/AND imm : opcode dr sr1 1 imm5
    //   NOT         : opcode dr sr1 1 11111
    //   LDR         : opcode dr base offset6
    //   STR         : opcode sr base offset6
    // offset6 spans imm_flag and low together
    typedef struct packed {
        lc3b_opcode opcode;
        lc3b_reg    dr;         // Store source on STR
        lc3b_reg    sr1;        // Base register on LDR/STR
        logic       imm_flag;   // Sign bit of offset6 on LDR/STR
        logic [4:0] low;        // sr2, imm5 or offset6[4:0]
    } lc3b_op_fields;

    // Branch layout
    //   BR : opcode n z p offset9
    typedef struct packed {
        lc3b_opcode opcode;
        lc3b_nzp    nzp;        // Condition mask
        logic [8:0] offset9;    // Word offset from PC+2
    } lc3b_br_fields;

    // One instruction word with two decodings
    typedef union packed {
        lc3b_op_fields op;
        lc3b_br_fields br;
    } lc3b_instr;

    // First fetch address after reset
    localparam lc3b_word reset_pc = 16'h0000;

    // BR with an empty mask never branches
    // Fills the barrier on reset and after a taken branch
    localparam lc3b_instr nop_instr = {op_br, 3'b000, 9'h000};

endpackage : lc3b_types

//--- regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic                 clk,
    input  logic                 rst,

    // Read ports
    input  lc3b_types::lc3b_reg  sr1,
    input  lc3b_types::lc3b_reg  sr2,
    output lc3b_types::lc3b_word sr1_data,
    output lc3b_types::lc3b_word sr2_data,

    // Write port
    input  logic                 load,
    input  lc3b_types::lc3b_reg  dest,
    input  lc3b_types::lc3b_word data
);

    lc3b_types::lc3b_word regs [8];

    // Write lands at the end of the execute cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (load) begin
            regs[dest] <= data;
        end
    end

    // Reads see the committed state of the previous instruction
    assign sr1_data = regs[sr1];
    assign sr2_data = regs[sr2];

endmodule : regfile

//--- stage_if.sv
`timescale 1ns/1ps

module stage_if (
    input  logic                 clk,
    input  logic                 rst,

    // Redirect from execute
    input  logic                 br_taken,
    input  lc3b_types::lc3b_word br_target,

    // Instruction memory
    output lc3b_types::lc3b_word imem_addr,
    input  lc3b_types::lc3b_word imem_rdata,

    // To the barrier
    output lc3b_types::lc3b_word fetch_ir,
    output lc3b_types::lc3b_word fetch_pc_plus2
);

    lc3b_types::lc3b_word pc;
    lc3b_types::lc3b_word pc_plus2;
    lc3b_types::lc3b_word next_pc;

    assign pc_plus2 = pc + 16'd2;

    // Branch from execute wins over sequential fetch
    always_comb begin
        next_pc = pc_plus2;
        if (br_taken) begin
            next_pc = br_target;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= lc3b_types::reset_pc;
        end else begin
            pc <= next_pc;
        end
    end

    assign imem_addr      = pc;          // Memory answers in the same cycle
    assign fetch_ir       = imem_rdata;
    assign fetch_pc_plus2 = pc_plus2;    // Base for branch targets

endmodule : stage_if

//--- barrier_if_ex.sv
`timescale 1ns/1ps

module barrier_if_ex (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,

    // From fetch
    input  lc3b_types::lc3b_word  ir_in,
    input  lc3b_types::lc3b_word  pc_in,

    // To execute
    output lc3b_types::lc3b_instr ir_out,
    output lc3b_types::lc3b_word  pc_out,
    output logic                  valid
);

    // Control part of the barrier
    // A flush turns the slot behind a taken branch into a bubble
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            ir_out <= lc3b_types::nop_instr;
            valid  <= 1'b0;
        end else begin
            ir_out <= ir_in;
            valid  <= 1'b1;
        end
    end

    // PC+2 of the fetched word
    always_ff @(posedge clk) begin
        pc_out <= pc_in;
    end

endmodule : barrier_if_ex

//--- stage_ex.sv
`timescale 1ns/1ps

module stage_ex (
    input  logic                  clk,
    input  logic                  rst,

    // From the barrier
    input  lc3b_types::lc3b_instr ir,
    input  lc3b_types::lc3b_word  pc,
    input  logic                  valid,

    // Redirect to fetch
    output logic                  br_taken,
    output lc3b_types::lc3b_word  br_target,

    // Data memory
    output lc3b_types::lc3b_word  dmem_addr,
    output lc3b_types::lc3b_word  dmem_wdata,
    output logic                  dmem_we,
    output logic                  dmem_re,
    input  lc3b_types::lc3b_word  dmem_rdata
);

    lc3b_types::lc3b_opcode opcode;
    lc3b_types::lc3b_reg    sr2_idx;
    lc3b_types::lc3b_word   sr1_data;
    lc3b_types::lc3b_word   sr2_data;
    lc3b_types::lc3b_word   imm5_sext;
    lc3b_types::lc3b_word   offset6_sext;
    lc3b_types::lc3b_word   offset9_sext;
    lc3b_types::lc3b_word   alu_b;
    lc3b_types::lc3b_word   alu_out;
    lc3b_types::lc3b_word   mem_addr;
    lc3b_types::lc3b_nzp    nzp;
    lc3b_types::lc3b_nzp    nzp_next;
    logic                   is_alu;
    logic                   is_ldr;
    logic                   is_str;
    logic                   is_br;
    logic                   wb_load;
    lc3b_types::lc3b_reg    wb_dest;
    lc3b_types::lc3b_word   wb_data;

    // Opcode sits at the same place in both views
    assign opcode = ir.op.opcode;

    // A bubble decodes to nothing
    assign is_alu = valid && (opcode == lc3b_types::op_add ||
                              opcode == lc3b_types::op_and ||
                              opcode == lc3b_types::op_not);
    assign is_ldr = valid && (opcode == lc3b_types::op_ldr);
    assign is_str = valid && (opcode == lc3b_types::op_str);
    assign is_br  = valid && (opcode == lc3b_types::op_br);

    // STR reads its data register through the dr field
    assign sr2_idx = (opcode == lc3b_types::op_str) ? ir.op.dr : ir.op.low[2:0];

    regfile i_regfile (
        .clk,
        .rst,
        .sr1      (ir.op.sr1),
        .sr2      (sr2_idx),
        .sr1_data (sr1_data),
        .sr2_data (sr2_data),
        .load     (wb_load),
        .dest     (wb_dest),
        .data     (wb_data)
    );

    // Immediates
    assign imm5_sext    = {{11{ir.op.low[4]}}, ir.op.low};
    assign offset6_sext = {{10{ir.op.imm_flag}}, ir.op.imm_flag, ir.op.low};
    assign offset9_sext = {{7{ir.br.offset9[8]}}, ir.br.offset9};

    assign alu_b = ir.op.imm_flag ? imm5_sext : sr2_data;

    always_comb begin
        case (opcode)
            lc3b_types::op_add: alu_out = sr1_data + alu_b;
            lc3b_types::op_and: alu_out = sr1_data & alu_b;
            lc3b_types::op_not: alu_out = ~sr1_data;
            default:            alu_out = '0;
        endcase
    end

    // Word offset scaled to bytes
    assign mem_addr = sr1_data + (offset6_sext << 1);

    assign dmem_addr  = mem_addr;
    assign dmem_wdata = sr2_data;
    assign dmem_we    = is_str;      // One cycle per STR
    assign dmem_re    = is_ldr;      // Data back in the same cycle

    // Writeback
    assign wb_load = is_alu || is_ldr;
    assign wb_dest = ir.op.dr;
    assign wb_data = is_ldr ? dmem_rdata : alu_out;

    // Condition codes from the value being written
    always_comb begin
        if (wb_data[15]) begin
            nzp_next = 3'b100;
        end else if (wb_data == '0) begin
            nzp_next = 3'b010;
        end else begin
            nzp_next = 3'b001;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            nzp <= '0;
        end else if (wb_load) begin
            nzp <= nzp_next;
        end
    end

    // pc already holds PC+2 of this branch
    assign br_taken  = is_br && ((ir.br.nzp & nzp) != '0);
    assign br_target = pc + (offset9_sext << 1);

endmodule : stage_ex

//--- cpu.sv
`timescale 1ns/1ps

module cpu (
    input  logic                 clk,
    input  logic                 rst,

    // Instruction memory
    output lc3b_types::lc3b_word imem_addr,
    input  lc3b_types::lc3b_word imem_rdata,

    // Data memory
    output lc3b_types::lc3b_word dmem_addr,
    output lc3b_types::lc3b_word dmem_wdata,
    output logic                 dmem_we,
    output logic                 dmem_re,
    input  lc3b_types::lc3b_word dmem_rdata
);

    // Branch feedback from execute
    logic                  br_taken;
    lc3b_types::lc3b_word  br_target;

    lc3b_types::lc3b_word  fetch_ir;
    lc3b_types::lc3b_word  fetch_pc_plus2;

    stage_if i_stage_if (
        .clk,
        .rst,
        .br_taken,
        .br_target,
        .imem_addr,
        .imem_rdata,
        .fetch_ir,
        .fetch_pc_plus2
    );

    lc3b_types::lc3b_instr ex_ir;
    lc3b_types::lc3b_word  ex_pc;
    logic                  ex_valid;

    // Taken branch squashes the instruction fetched behind it
    barrier_if_ex i_barrier_if_ex (
        .clk,
        .rst,
        .flush  (br_taken),
        .ir_in  (fetch_ir),
        .pc_in  (fetch_pc_plus2),
        .ir_out (ex_ir),
        .pc_out (ex_pc),
        .valid  (ex_valid)
    );

    stage_ex i_stage_ex (
        .clk,
        .rst,
        .ir    (ex_ir),
        .pc    (ex_pc),
        .valid (ex_valid),
        .br_taken,
        .br_target,
        .dmem_addr,
        .dmem_wdata,
        .dmem_we,
        .dmem_re,
        .dmem_rdata
    );

endmodule : cpu

//--- tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;

    localparam int clk_period      = 20;
    localparam int prog_len        = 200;
    localparam int cycle_bound     = prog_len * 2;
    localparam int watchdog_cycles = prog_len * 2 + 50;
    localparam lc3b_types::lc3b_word prog_end = lc3b_types::lc3b_word'(prog_len * 2);

    logic                 clk = 1'b0;
    logic                 rst = 1'b1;
    lc3b_types::lc3b_word imem_addr;
    lc3b_types::lc3b_word imem_rdata;
    lc3b_types::lc3b_word dmem_addr;
    lc3b_types::lc3b_word dmem_wdata;
    lc3b_types::lc3b_word dmem_rdata;
    logic                 dmem_we;
    logic                 dmem_re;

    lc3b_types::lc3b_word imem [256];
    lc3b_types::lc3b_word dmem [64];
    logic                 wr_pending = 1'b0;
    logic [5:0]           wr_addr;
    lc3b_types::lc3b_word wr_data;

    // Expected bus accesses in program order
    bit                   exp_is_store [$];
    lc3b_types::lc3b_word exp_addr [$];
    lc3b_types::lc3b_word exp_data [$];

    logic [31:0] rng_state = 32'd14788;
    int          prog_count = 0;
    int          mismatches = 0;
    int          other_errors = 0;
    int          stores_seen = 0;
    int          loads_seen = 0;
    int          model_stores = 0;

    cpu i_dut (
        .clk,
        .rst,
        .imem_addr,
        .imem_rdata,
        .dmem_addr,
        .dmem_wdata,
        .dmem_we,
        .dmem_re,
        .dmem_rdata
    );

    always #(clk_period / 2) clk = ~clk;

    // Both memories answer in the same cycle
    assign imem_rdata = (imem_addr < prog_end) ? imem[imem_addr[8:1]] : lc3b_types::nop_instr;
    assign dmem_rdata = dmem[dmem_addr[6:1]];

    function automatic logic [31:0] rand_next();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic lc3b_types::lc3b_word fill_value(input logic [5:0] idx);
        return ({10'd0, idx} * 16'h9E37) ^ 16'h5A3C;
    endfunction

    function automatic lc3b_types::lc3b_word enc(input logic [3:0] op, input logic [2:0] a,
                                                 input logic [2:0] b, input logic [5:0] low);
        return {op, a, b, low};
    endfunction

    // Random destinations never touch the loop counter R5 or the data base R6
    function automatic lc3b_types::lc3b_reg pick_dest();
        logic [31:0] x;
        lc3b_types::lc3b_reg r;
        x = rand_next();
        r = x[2:0];
        if (r == 3'd5 || r == 3'd6) begin
            r = {1'b0, x[4:3]};
        end
        return r;
    endfunction

    function automatic lc3b_types::lc3b_word random_body();
        logic [31:0] x;
        lc3b_types::lc3b_reg d;
        x = rand_next();
        d = pick_dest();
        case (x[2:0])
            3'd0:    return enc(lc3b_types::op_ldr, d, 3'd6, x[8:3]);
            3'd1:    return enc(lc3b_types::op_str, x[5:3], 3'd6, x[11:6]);
            3'd2:    return enc(lc3b_types::op_add, d, x[5:3], {3'b000, x[8:6]});
            3'd3:    return enc(lc3b_types::op_and, d, x[5:3], {3'b000, x[8:6]});
            3'd4:    return enc(lc3b_types::op_and, d, x[5:3], {1'b1, x[10:6]});
            3'd5:    return enc(lc3b_types::op_not, d, x[5:3], 6'b111111);
            default: return enc(lc3b_types::op_add, d, x[5:3], {1'b1, x[10:6]});
        endcase
    endfunction

    task automatic emit(input lc3b_types::lc3b_word w);
        imem[prog_count[7:0]] = w;
        prog_count++;
    endtask

    // Counted loop of up to three passes closed by a backward BRp
    task automatic emit_loop();
        logic [31:0] x;
        logic [2:0]  count;
        logic [8:0]  back;
        int          body;
        x = rand_next();
        body = int'(x[1:0]) + 1;
        count = (x[3:2] == 2'd0) ? 3'd1 : {1'b0, x[3:2]};
        back = 9'(-(body + 2));
        emit(enc(lc3b_types::op_and, 3'd5, 3'd5, 6'b100000));
        emit(enc(lc3b_types::op_add, 3'd5, 3'd5, {3'b100, count}));
        repeat (body) emit(random_body());
        emit(enc(lc3b_types::op_add, 3'd5, 3'd5, 6'b111111));   // R5 minus one
        emit(enc(lc3b_types::op_br, 3'b001, back[8:6], back[5:0]));
    endtask

    task automatic build_program();
        logic [31:0] x;
        int          kind;
        for (int i = 0; i < 256; i++) begin
            imem[i[7:0]] = lc3b_types::nop_instr;
        end
        // R6 = 64, so base plus offset6 stays inside the data memory
        emit(enc(lc3b_types::op_and, 3'd6, 3'd6, 6'b100000));
        repeat (4) emit(enc(lc3b_types::op_add, 3'd6, 3'd6, 6'b101111));
        emit(enc(lc3b_types::op_add, 3'd6, 3'd6, 6'b100100));
        while (prog_count < prog_len) begin
            x = rand_next();
            kind = int'(x[3:0]);
            if (kind == 0 && prog_count + 8 <= prog_len) begin
                emit_loop();
            end else if (kind < 3) begin
                emit(enc(lc3b_types::op_br, x[6:4], 3'b000, {2'b00, x[10:7]}));  // Forward
            end else if (kind == 3) begin
                emit({4'b1101, x[15:4]});     // Unsupported opcode
            end else begin
                emit(random_body());
            end
        end
    endtask

    function automatic lc3b_types::lc3b_nzp cond_of(input lc3b_types::lc3b_word v);
        if (v[15]) begin
            return 3'b100;
        end
        return (v == 16'h0000) ? 3'b010 : 3'b001;
    endfunction

    // Sequential ISA model that runs one instruction at a time
    task automatic run_model();
        lc3b_types::lc3b_word regs [8];
        lc3b_types::lc3b_word mem [64];
        lc3b_types::lc3b_word pc;
        lc3b_types::lc3b_word w;
        lc3b_types::lc3b_word b;
        lc3b_types::lc3b_word res;
        lc3b_types::lc3b_word addr;
        lc3b_types::lc3b_nzp  cc;
        int                   cycles;
        for (int i = 0; i < 8; i++) begin
            regs[i[2:0]] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            mem[i[5:0]] = fill_value(i[5:0]);
        end
        pc = lc3b_types::reset_pc;
        cc = '0;
        cycles = 0;
        while (pc < prog_end && cycles <= cycle_bound) begin
            w = imem[pc[8:1]];
            pc = pc + 16'd2;
            cycles++;
            b = w[5] ? {{11{w[4]}}, w[4:0]} : regs[w[2:0]];
            addr = regs[w[8:6]] + {{9{w[5]}}, w[5:0], 1'b0};
            res = '0;
            case (w[15:12])
                lc3b_types::op_add: res = regs[w[8:6]] + b;
                lc3b_types::op_and: res = regs[w[8:6]] & b;
                lc3b_types::op_not: res = ~regs[w[8:6]];
                lc3b_types::op_ldr: begin
                    res = mem[addr[6:1]];
                    exp_is_store.push_back(1'b0);
                    exp_addr.push_back(addr);
                    exp_data.push_back(16'h0000);
                end
                lc3b_types::op_str: begin
                    mem[addr[6:1]] = regs[w[11:9]];
                    exp_is_store.push_back(1'b1);
                    exp_addr.push_back(addr);
                    exp_data.push_back(regs[w[11:9]]);
                    model_stores++;
                end
                lc3b_types::op_br: begin
                    if ((w[11:9] & cc) != 3'b000) begin
                        pc = pc + {{6{w[8]}}, w[8:0], 1'b0};
                        cycles++;                        // Slot lost to the flush
                    end
                end
                default: ;
            endcase
            if (w[15:12] inside {lc3b_types::op_add, lc3b_types::op_and,
                                 lc3b_types::op_not, lc3b_types::op_ldr}) begin
                regs[w[11:9]] = res;
                cc = cond_of(res);
            end
        end
        if (cycles > cycle_bound) begin
            $display("Reference model did not finish the program within %0d cycles", cycle_bound);
            other_errors++;
        end
    endtask

    task automatic compare_word(input string name, input lc3b_types::lc3b_word got,
                                input lc3b_types::lc3b_word exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
            mismatches++;
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
            mismatches++;
        end
    endtask

    task automatic drop_front();
        void'(exp_is_store.pop_front());
        void'(exp_addr.pop_front());
        void'(exp_data.pop_front());
    endtask

    task automatic check_store(input lc3b_types::lc3b_word addr, input lc3b_types::lc3b_word data);
        stores_seen++;
        if (exp_is_store.size() == 0) begin
            $display("Extra store to %h at %0t after the last expected access", addr, $time);
            other_errors++;
        end else begin
            if (!exp_is_store[0]) begin
                $display("Store to %h at %0t where a load was expected", addr, $time);
                other_errors++;
            end else begin
                compare_word("dmem_addr", addr, exp_addr[0]);
                compare_word("dmem_wdata", data, exp_data[0]);
            end
            drop_front();
        end
    endtask

    task automatic check_load(input lc3b_types::lc3b_word addr);
        loads_seen++;
        if (exp_is_store.size() == 0) begin
            $display("Extra load from %h at %0t after the last expected access", addr, $time);
            other_errors++;
        end else begin
            if (exp_is_store[0]) begin
                $display("Load from %h at %0t where a store was expected", addr, $time);
                other_errors++;
            end else begin
                compare_word("dmem_addr", addr, exp_addr[0]);
            end
            drop_front();
        end
    endtask

    task automatic check_reset();
        compare_word("imem_addr", imem_addr, lc3b_types::reset_pc);
        compare_bit("dmem_we", dmem_we, 1'b0);
        compare_bit("dmem_re", dmem_re, 1'b0);
    endtask

    task automatic print_counts();
        $display("Error counts: %0d mismatches, %0d other failures (stores %0d, loads %0d)",
                 mismatches, other_errors, stores_seen, loads_seen);
    endtask

    // Bus monitor samples the settled outputs at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            if (dmem_we === 1'b1) begin
                check_store(dmem_addr, dmem_wdata);
                wr_pending = 1'b1;
                wr_addr = dmem_addr[6:1];
                wr_data = dmem_wdata;
            end
            if (dmem_re === 1'b1) begin
                check_load(dmem_addr);
            end
        end
    end

    // Store lands in memory just after the edge that ends it
    always @(posedge clk) begin
        #1;
        if (wr_pending) begin
            dmem[wr_addr] = wr_data;
            wr_pending = 1'b0;
        end
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("Watchdog expired after %0d cycles before the program finished",
                 watchdog_cycles);
        print_counts();
        $display("Done: errors found");
        $finish;
    end

    initial begin
        int quiet;
        for (int i = 0; i < 64; i++) begin
            dmem[i[5:0]] = fill_value(i[5:0]);
        end
        build_program();
        run_model();
        repeat (2) @(posedge clk);
        #1;
        check_reset();
        rst = 1'b0;

        // Finished once fetch stays past the program for two cycles
        quiet = 0;
        while (quiet < 2) begin
            @(negedge clk);
            if (imem_addr >= prog_end) begin
                quiet++;
            end else begin
                quiet = 0;
            end
        end
        @(posedge clk);

        if (exp_is_store.size() != 0) begin
            $display("%0d expected memory accesses never appeared on the bus",
                     exp_is_store.size());
            other_errors++;
        end
        if (stores_seen != model_stores) begin
            $display("Store count differs: %0d seen, %0d expected", stores_seen, model_stores);
            other_errors++;
        end
        print_counts();
        if (mismatches + other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule : tb_cpu

//--- all.f
lc3b_types.sv
regfile.sv
stage_if.sv
barrier_if_ex.sv
stage_ex.sv
cpu.sv
tb_cpu.sv

//--- run.sh
#!/usr/bin/env bash
# Build the LC-3b core and its testbench with Verilator, then run it

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir

verilator --binary --timing -f all.f --top-module tb_cpu -Mdir "$build_dir" -o tb_cpu
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$("$build_dir"/tb_cpu)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# Pass only when the testbench printed its pass line
if echo "$output" | grep -qx "Done: no errors"; then
    exit 0
fi
echo "Simulation reported failures"
exit 1
